// ==== common/sram_settings.svh ====
`ifndef SRAM_SETTINGS_SVH
`define SRAM_SETTINGS_SVH

// external chip geometry
`define SRAM_ADDR_BITS 18
`define SRAM_DATA_BITS 16

// clocks a write command keeps ce_n low
// we_n is asserted in all of them but the last
`define SRAM_WRITE_CYCLES 2

// clocks a read command keeps ce_n low
// oe_n is asserted in all of them but the last
`define SRAM_READ_CYCLES 2

`endif

// ==== common/sram_req_pkg.sv ====
`include "sram_settings.svh"

// user side of the controller
package sram_req_pkg;

  // one single-word request from the user
  // the data field only matters for writes
  typedef struct packed {
    logic                       write;
    logic [`SRAM_ADDR_BITS-1:0] addr;
    logic [`SRAM_DATA_BITS-1:0] data;
  } sram_req_t;

  // one read result
  // tagged with the address it was read from
  typedef struct packed {
    logic [`SRAM_ADDR_BITS-1:0] addr;
    logic [`SRAM_DATA_BITS-1:0] data;
  } sram_rsp_t;

endpackage

// ==== common/sram_pin_pkg.sv ====
`include "sram_settings.svh"

// pin side of the controller
package sram_pin_pkg;

  // pin levels requested for the next clock
  // strobes are active low, data_en drives the bus
  typedef struct packed {
    logic                       ce_n;
    logic                       we_n;
    logic                       oe_n;
    logic                       data_en;
    logic [`SRAM_ADDR_BITS-1:0] addr;
    logic [`SRAM_DATA_BITS-1:0] data;
  } sram_pin_cmd_t;

  // chip deselected and bus released
  localparam sram_pin_cmd_t cmd_idle = '{
    ce_n:    1'b1,
    we_n:    1'b1,
    oe_n:    1'b1,
    data_en: 1'b0,
    addr:    '0,
    data:    '0
  };

endpackage

// ==== design/sram_req_holder.sv ====
`timescale 1ns/1ps

// one-deep holding register in front of the sequencer
module sram_req_holder (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_valid,
  input  sram_req_pkg::sram_req_t req,
  input  logic                    take,
  input  logic                    seq_idle,
  output logic                    hold_valid,
  output sram_req_pkg::sram_req_t hold_req,
  output logic                    busy
);

  // occupancy
  // a new strobe wins over take, so a request strobed in the
  // same cycle the old entry leaves is still kept
  always_ff @(posedge clk) begin
    if (reset) begin
      hold_valid <= 1'b0;
    end else if (req_valid) begin
      hold_valid <= 1'b1;
    end else if (take) begin
      hold_valid <= 1'b0;
    end
  end

  // stored request
  always_ff @(posedge clk) begin
    if (req_valid) begin
      hold_req <= req;
    end
  end

  // entry waits behind a running access
  // an idle sequencer drains it on the next clock
  assign busy = hold_valid && !seq_idle;

endmodule

// ==== sram_ctrl/sram_ctrl_fsm.sv ====
`timescale 1ns/1ps
`include "sram_settings.svh"

// access sequencer, one word per access
module sram_ctrl_fsm (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        hold_valid,
  input  sram_req_pkg::sram_req_t     hold_req,
  output logic                        take,
  output logic                        seq_idle,
  output sram_pin_pkg::sram_pin_cmd_t cmd,
  input  logic [`SRAM_DATA_BITS-1:0]  pad_rd_data,
  input  logic                        pad_rd_valid,
  output logic                        rsp_valid,
  output sram_req_pkg::sram_rsp_t     rsp
);

  // counter sized for the longer of the two accesses
  localparam int cnt_max = (`SRAM_WRITE_CYCLES > `SRAM_READ_CYCLES) ?
                           `SRAM_WRITE_CYCLES : `SRAM_READ_CYCLES;
  localparam int cnt_bits = $clog2(cnt_max + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_read,
    st_recover
  } state_t;

  state_t                     state;
  logic [cnt_bits-1:0]        cnt;
  logic                       last;
  sram_req_pkg::sram_req_t    acc;
  logic [`SRAM_ADDR_BITS-1:0] rd_addr;

  assign seq_idle = (state == st_idle);

  // an access starts the clock after take
  assign take = seq_idle && hold_valid;

  // final clock of the running access
  always_comb begin
    if (state == st_write) begin
      last = (cnt == cnt_bits'(`SRAM_WRITE_CYCLES - 1));
    end else begin
      last = (cnt == cnt_bits'(`SRAM_READ_CYCLES - 1));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          cnt <= '0;
          if (hold_valid) begin
            state <= hold_req.write ? st_write : st_read;
          end
        end
        st_write, st_read: begin
          if (last) begin
            state <= st_recover;
            cnt   <= '0;
          end else begin
            cnt <= cnt + cnt_bits'(1);
          end
        end
        // one clock with every pin inactive
        default: state <= st_idle;
      endcase
    end
  end

  // current access and the address of the read in flight
  always_ff @(posedge clk) begin
    if (take) begin
      acc <= hold_req;
      if (!hold_req.write) begin
        rd_addr <= hold_req.addr;
      end
    end
  end

  // pin command
  // ce_n spans the whole access while we_n/oe_n drop one clock early,
  // so the half-clock shift in the pad keeps them inside the ce_n window
  always_comb begin
    cmd = sram_pin_pkg::cmd_idle;
    if (state == st_write || state == st_read) begin
      cmd.ce_n = 1'b0;
      cmd.addr = acc.addr;
    end
    if (state == st_write) begin
      cmd.we_n    = last;
      cmd.data_en = 1'b1;
      cmd.data    = acc.data;
    end
    if (state == st_read) begin
      cmd.oe_n = last;
    end
  end

  // response pulse, one clock after the pad flags its capture
  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= pad_rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pad_rd_valid) begin
      rsp.addr <= rd_addr;
      rsp.data <= pad_rd_data;
    end
  end

endmodule

// ==== sram_ctrl/sram_io_pad.sv ====
`timescale 1ns/1ps
`include "sram_settings.svh"

// pin registers for the external chip
// plain RTL model of the registered and DDR pad cells
module sram_io_pad (
  input  logic                        clk,
  input  sram_pin_pkg::sram_pin_cmd_t cmd,
  output logic [`SRAM_DATA_BITS-1:0]  pad_rd_data,
  output logic                        pad_rd_valid,
  output logic [`SRAM_ADDR_BITS-1:0]  sram_addr,
  output logic                        sram_ce_n,
  output logic                        sram_we_n,
  output logic                        sram_oe_n,
  output logic [`SRAM_DATA_BITS-1:0]  sram_data_out,
  output logic                        sram_data_oe,
  input  logic [`SRAM_DATA_BITS-1:0]  sram_data_in
);

  logic we_n_pos;
  logic oe_n_pos;
  logic oe_act_p1;
  logic oe_act_p2;

  // posedge output registers
  // all of them settle inactive while the sequencer sits in reset
  always_ff @(posedge clk) begin
    sram_addr     <= cmd.addr;
    sram_ce_n     <= cmd.ce_n;
    sram_data_out <= cmd.data;
    sram_data_oe  <= cmd.data_en;
    we_n_pos      <= cmd.we_n;
    oe_n_pos      <= cmd.oe_n;
  end

  // falling edge stage of the DDR pair
  // strobes move half a clock behind ce_n and the address
  always_ff @(negedge clk) begin
    sram_we_n <= we_n_pos;
    sram_oe_n <= oe_n_pos;
  end

  // read capture on the falling edge while oe_n is still low
  // the last capture lands in the final clock of the oe_n window
  always_ff @(negedge clk) begin
    if (!sram_oe_n) begin
      pad_rd_data <= sram_data_in;
    end
  end

  // output enable pipeline
  assign oe_act_p1 = !oe_n_pos;

  always_ff @(posedge clk) begin
    oe_act_p2 <= oe_act_p1;
  end

  // high for the one clock in which the oe_n pin releases mid-cycle
  assign pad_rd_valid = oe_act_p2 && !oe_act_p1;

endmodule

// ==== design/sram_subsystem.sv ====
`timescale 1ns/1ps
`include "sram_settings.svh"

// holder, sequencer and pad in a chain
module sram_subsystem (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_valid,
  input  sram_req_pkg::sram_req_t    req,
  output logic                       busy,
  output logic                       rsp_valid,
  output sram_req_pkg::sram_rsp_t    rsp,
  output logic [`SRAM_ADDR_BITS-1:0] sram_addr,
  output logic                       sram_ce_n,
  output logic                       sram_we_n,
  output logic                       sram_oe_n,
  output logic [`SRAM_DATA_BITS-1:0] sram_data_out,
  output logic                       sram_data_oe,
  input  logic [`SRAM_DATA_BITS-1:0] sram_data_in
);

  logic                        hold_valid;
  sram_req_pkg::sram_req_t     hold_req;
  logic                        take;
  logic                        seq_idle;
  sram_pin_pkg::sram_pin_cmd_t cmd;
  logic [`SRAM_DATA_BITS-1:0]  pad_rd_data;
  logic                        pad_rd_valid;

  sram_req_holder sram_req_holder_i (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .take       (take),
    .seq_idle   (seq_idle),
    .hold_valid (hold_valid),
    .hold_req   (hold_req),
    .busy       (busy)
  );

  sram_ctrl_fsm sram_ctrl_fsm_i (
    .clk          (clk),
    .reset        (reset),
    .hold_valid   (hold_valid),
    .hold_req     (hold_req),
    .take         (take),
    .seq_idle     (seq_idle),
    .cmd          (cmd),
    .pad_rd_data  (pad_rd_data),
    .pad_rd_valid (pad_rd_valid),
    .rsp_valid    (rsp_valid),
    .rsp          (rsp)
  );

  // bidirectional bus stays split into out, enable and in
  sram_io_pad sram_io_pad_i (
    .clk           (clk),
    .cmd           (cmd),
    .pad_rd_data   (pad_rd_data),
    .pad_rd_valid  (pad_rd_valid),
    .sram_addr     (sram_addr),
    .sram_ce_n     (sram_ce_n),
    .sram_we_n     (sram_we_n),
    .sram_oe_n     (sram_oe_n),
    .sram_data_out (sram_data_out),
    .sram_data_oe  (sram_data_oe),
    .sram_data_in  (sram_data_in)
  );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

// free running clock and a reset held for the first two cycles
module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = !clk;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== test/sram_chip_model.sv ====
`timescale 1ns/1ps
`include "sram_settings.svh"

// behavioural asynchronous SRAM on the split data bus
module sram_chip_model (
  input  logic [`SRAM_ADDR_BITS-1:0] sram_addr,
  input  logic                       sram_ce_n,
  input  logic                       sram_we_n,
  input  logic                       sram_oe_n,
  input  logic [`SRAM_DATA_BITS-1:0] sram_data_out,
  input  logic                       sram_data_oe,
  output logic [`SRAM_DATA_BITS-1:0] sram_data_in
);

  logic [`SRAM_DATA_BITS-1:0] mem [0:(1 << `SRAM_ADDR_BITS)-1];
  logic [`SRAM_DATA_BITS-1:0] bus;

  // what the chip sees on its data pins
  assign bus = sram_data_oe ? sram_data_out : 'x;

  // level sensitive write while selected and write enabled
  always @(sram_ce_n or sram_we_n or sram_addr or bus) begin
    if (!sram_ce_n && !sram_we_n) begin
      mem[sram_addr] = bus;
    end
  end

  // chip drives the bus only while selected with output enable low
  assign sram_data_in = (!sram_ce_n && !sram_oe_n) ? mem[sram_addr] : 'x;

endmodule

// ==== test/sram_subsystem_assertions.sv ====
`timescale 1ns/1ps

// pin and strobe rules checked on the top level
module sram_subsystem_assertions (
  input logic clk,
  input logic reset,
  input logic req_valid,
  input logic busy,
  input logic rsp_valid,
  input logic sram_we_n,
  input logic sram_oe_n,
  input logic sram_data_oe
);

  // write and read strobes are exclusive
  assert property (@(posedge clk) disable iff (reset) !(!sram_we_n && !sram_oe_n))
    else $error("we_n and oe_n low together");

  // no bus fight with the chip
  assert property (@(posedge clk) disable iff (reset) !(sram_data_oe && !sram_oe_n))
    else $error("data_oe high while oe_n low");

  // user side must respect busy
  assert property (@(posedge clk) disable iff (reset) req_valid |-> !busy)
    else $error("req_valid while busy");

  // single cycle response pulse
  assert property (@(posedge clk) disable iff (reset) rsp_valid |=> !rsp_valid)
    else $error("rsp_valid wider than one cycle");

endmodule

bind sram_subsystem sram_subsystem_assertions sram_subsystem_assertions_i (.*);

// ==== test/tb_sram_subsystem.sv ====
`timescale 1ns/1ps
`include "sram_settings.svh"

module tb_sram_subsystem;

  // requests issued over all tests, sizes the watchdog
  localparam int num_requests = 41;

  logic clk;
  logic reset;
  logic req_valid;
  sram_req_pkg::sram_req_t req;
  logic busy;
  logic rsp_valid;
  sram_req_pkg::sram_rsp_t rsp;
  logic [`SRAM_ADDR_BITS-1:0] sram_addr;
  logic sram_ce_n;
  logic sram_we_n;
  logic sram_oe_n;
  logic [`SRAM_DATA_BITS-1:0] sram_data_out;
  logic sram_data_oe;
  logic [`SRAM_DATA_BITS-1:0] sram_data_in;

  int errors = 0;
  int tests_ok = 0;
  int tests_bad = 0;
  int seed = 72;
  int data_oe_cycles = 0;
  int busy_cycles = 0;
  sram_req_pkg::sram_rsp_t rsp_q [$];
  sram_req_pkg::sram_rsp_t exp_q [$];
  logic [`SRAM_DATA_BITS-1:0] shadow [logic [`SRAM_ADDR_BITS-1:0]];

  tb_clock_gen tb_clock_gen_i (.clk(clk), .reset(reset));

  sram_subsystem sram_subsystem_i (.*);

  sram_chip_model sram_chip_model_i (
    .sram_addr     (sram_addr),
    .sram_ce_n     (sram_ce_n),
    .sram_we_n     (sram_we_n),
    .sram_oe_n     (sram_oe_n),
    .sram_data_out (sram_data_out),
    .sram_data_oe  (sram_data_oe),
    .sram_data_in  (sram_data_in)
  );

  // collect responses and count bus drive cycles mid-cycle
  always @(negedge clk) begin
    if (rsp_valid) begin
      rsp_q.push_back(rsp);
    end
    if (sram_data_oe) begin
      data_oe_cycles = data_oe_cycles + 1;
    end
    if (busy) begin
      busy_cycles = busy_cycles + 1;
    end
  end

  task automatic check_rsp(input string name, input sram_req_pkg::sram_rsp_t exp,
                           input sram_req_pkg::sram_rsp_t act);
    if (exp !== act) begin
      $display("Error %s: expected %h actual %h", name, exp, act);
      errors = errors + 1;
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Error %s: expected %h actual %h", name, exp, act);
      errors = errors + 1;
    end
  endtask

  task automatic wait_not_busy();
    int n;
    n = 0;
    @(negedge clk);
    while (busy && n < 200) begin
      n = n + 1;
      @(negedge clk);
    end
    if (busy) begin
      $display("timeout: busy stayed high for 200 cycles");
      errors = errors + 1;
    end
  endtask

  // drained once the chip stays deselected with nothing waiting
  task automatic wait_drained();
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < 3 && n < 200) begin
      @(negedge clk);
      n = n + 1;
      quiet = (sram_ce_n && !busy) ? quiet + 1 : 0;
    end
    if (quiet < 3) begin
      $display("timeout: accesses did not drain within 200 cycles");
      errors = errors + 1;
    end
  endtask

  task automatic issue(input logic write, input logic [`SRAM_ADDR_BITS-1:0] addr,
                       input logic [`SRAM_DATA_BITS-1:0] data);
    wait_not_busy();
    @(posedge clk);
    req_valid <= 1'b1;
    req <= '{write: write, addr: addr, data: data};
    @(posedge clk);
    req_valid <= 1'b0;
    if (write) begin
      shadow[addr] = data;
    end else begin
      exp_q.push_back('{addr: addr, data: shadow[addr]});
    end
  endtask

  // wait for all expected reads, then compare in request order
  task automatic compare_responses(input string name);
    int n;
    n = 0;
    while (rsp_q.size() < exp_q.size() && n < 400) begin
      @(negedge clk);
      n = n + 1;
    end
    if (rsp_q.size() < exp_q.size()) begin
      $display("timeout: %0d responses missing in %s", exp_q.size() - rsp_q.size(), name);
      errors = errors + 1;
    end
    while (exp_q.size() > 0 && rsp_q.size() > 0) begin
      check_rsp({name, " rsp"}, exp_q.pop_front(), rsp_q.pop_front());
    end
    exp_q.delete();
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_ok = tests_ok + 1;
      $display("test %s: ok", name);
    end else begin
      tests_bad = tests_bad + 1;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end
    check_level("sram_ce_n", 1'b1, sram_ce_n);
    check_level("sram_we_n", 1'b1, sram_we_n);
    check_level("sram_oe_n", 1'b1, sram_oe_n);
    check_level("sram_data_oe", 1'b0, sram_data_oe);
    check_level("busy", 1'b0, busy);
    check_level("rsp_valid", 1'b0, rsp_valid);
    finish_test("reset_state", e0);
  endtask

  task automatic test_write_read();
    int e0;
    e0 = errors;
    issue(1'b1, 18'h0_1234, 16'hbeef);
    issue(1'b0, 18'h0_1234, 16'h0000);
    compare_responses("write_read");
    finish_test("write_read", e0);
  endtask

  task automatic test_random();
    logic [`SRAM_ADDR_BITS-1:0] addrs [16];
    logic [`SRAM_ADDR_BITS-1:0] tmp;
    logic [31:0] r;
    int j;
    int e0;
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      addrs[i] = r[`SRAM_ADDR_BITS-1:0];
      r = $random(seed);
      issue(1'b1, addrs[i], r[`SRAM_DATA_BITS-1:0]);
    end
    // shuffle read order
    for (int i = 15; i > 0; i--) begin
      r = $random(seed);
      j = int'(r[7:0]) % (i + 1);
      tmp = addrs[i];
      addrs[i] = addrs[j];
      addrs[j] = tmp;
    end
    for (int i = 0; i < 16; i++) begin
      issue(1'b0, addrs[i], 16'h0000);
    end
    compare_responses("random");
    finish_test("random", e0);
  endtask

  task automatic test_holder();
    int e0;
    int busy_before;
    e0 = errors;
    issue(1'b1, 18'h2_0040, 16'h5a5a);
    wait_drained();
    issue(1'b1, 18'h2_0040, 16'hc3c3);
    busy_before = busy_cycles;
    // read lands in the holder while the write runs
    issue(1'b0, 18'h2_0040, 16'h0000);
    @(negedge clk);
    check_level("busy", 1'b1, busy);
    wait_not_busy();
    // held through the rest of the write and its idle clock
    if (busy_cycles - busy_before != `SRAM_WRITE_CYCLES) begin
      $display("Error busy cycles: expected %h actual %h",
               `SRAM_WRITE_CYCLES, busy_cycles - busy_before);
      errors = errors + 1;
    end
    compare_responses("holder");
    finish_test("holder", e0);
  endtask

  task automatic test_writes_only();
    int e0;
    int oe_before;
    int rsp_before;
    e0 = errors;
    wait_drained();
    oe_before = data_oe_cycles;
    rsp_before = rsp_q.size();
    for (int i = 0; i < 4; i++) begin
      issue(1'b1, 18'h3_0100 + 18'(i), 16'h1000 + 16'(i));
    end
    wait_drained();
    check_level("rsp_valid_seen", 1'b0, rsp_q.size() != rsp_before);
    if (data_oe_cycles - oe_before != 4 * `SRAM_WRITE_CYCLES) begin
      $display("Error sram_data_oe cycles: expected %h actual %h",
               4 * `SRAM_WRITE_CYCLES, data_oe_cycles - oe_before);
      errors = errors + 1;
    end
    finish_test("writes_only", e0);
  endtask

  initial begin
    req_valid <= 1'b0;
    req <= '0;
    test_reset_state();
    test_write_read();
    test_random();
    test_holder();
    test_writes_only();
    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // 200 cycles per request plus margin
  initial begin
    #((num_requests * 200 + 100) * 10);
    $display("watchdog expired before the tests finished");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+common
common/sram_req_pkg.sv
common/sram_pin_pkg.sv
design/sram_req_holder.sv
sram_ctrl/sram_ctrl_fsm.sv
sram_ctrl/sram_io_pad.sv
design/sram_subsystem.sv
test/tb_clock_gen.sv
test/sram_chip_model.sv
test/sram_subsystem_assertions.sv
test/tb_sram_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the SRAM subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    -f sim.f \
    --top-module tb_sram_subsystem \
    --Mdir obj_dir -o tb_sim; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi

echo "pass message not found"
exit 1
